// File: source/load_issue_pkg.sv
/*
 * load issue shared definitions
 * widths, memory size encoding and the packed structs passed
 * between the dispatch register, reservation station and agen
 */

`default_nettype none

package load_issue_pkg;

    localparam int xlen   = 32;  // data and address width
    localparam int preg_w = 6;   // physical register tag
    localparam int rob_w  = 5;
    localparam int lb_w   = 3;   // load buffer index

    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;

    // one common data bus broadcast
    typedef struct packed {
        logic              valid;
        logic [preg_w-1:0] tag;
        logic [xlen-1:0]   value;
    } cdb_t;

    // base holds the tag in its low bits until base_ready
    typedef struct packed {
        logic              base_ready;
        logic [xlen-1:0]   base;
        logic [xlen-1:0]   offset;
        logic [preg_w-1:0] dest_preg;
        logic [rob_w-1:0]  rob_idx;
        logic [lb_w-1:0]   lb_idx;
        mem_size_e         mem_size;
        logic              load_signed;
    } load_dispatch_t;

    typedef struct packed {
        logic [xlen-1:0]   addr;
        logic [preg_w-1:0] dest_preg;
        logic [rob_w-1:0]  rob_idx;
        logic [lb_w-1:0]   lb_idx;
        mem_size_e         mem_size;
        logic              load_signed;
    } load_req_t;

endpackage

`default_nettype wire

// File: source/dispatch_stage.sv
/*
 * dispatch register
 * holds one dispatched load for a cycle and folds that cycle's
 * CDB broadcast into the copy forwarded to the reservation station
 */

`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
    input  wire logic                           clock,
    input  wire logic                           arst_n,
    input  wire logic                           flush,
    input  wire logic                           disp_valid,
    input  wire load_issue_pkg::load_dispatch_t disp,
    input  wire load_issue_pkg::cdb_t           cdb,
    output logic                                fwd_valid,
    output load_issue_pkg::load_dispatch_t      fwd
);

    logic                           held_valid;
    load_issue_pkg::load_dispatch_t held_q;
    logic                           tag_hit;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            held_valid <= 1'b0;
        end else begin
            held_valid <= disp_valid && !flush;  // a load arriving with flush is dropped
        end
    end

    always_ff @(posedge clock) begin
        if (disp_valid) begin
            held_q <= disp;
        end
    end

    // wakeup of the held copy, same compare the station uses
    assign tag_hit = cdb.valid && !held_q.base_ready
                     && (held_q.base[load_issue_pkg::preg_w-1:0] == cdb.tag);

    always_comb begin
        fwd = held_q;
        if (tag_hit) begin
            fwd.base_ready = 1'b1;
            fwd.base       = cdb.value;  // operand replaces the tag
        end
    end

    assign fwd_valid = held_valid;

    // forwarded load must be fully defined, the station writes it blindly
    a_fwd_known: assert property (@(posedge clock) disable iff (!arst_n)
        !$isunknown(fwd_valid) && (!fwd_valid || !$isunknown(fwd)));

endmodule

`default_nettype wire

// File: source/load_rs.sv
/*
 * load reservation station
 * stores forwarded loads, wakes them on CDB tag match and issues
 * the lowest ready entry while the load buffer has credit
 */

`timescale 1ns/1ps
`default_nettype none

module load_rs #(
    parameter int rs_depth = 8
) (
    input  wire logic                           clock,
    input  wire logic                           arst_n,
    input  wire logic                           flush,
    input  wire logic                           fwd_valid,
    input  wire load_issue_pkg::load_dispatch_t fwd,
    input  wire load_issue_pkg::cdb_t           cdb,
    input  wire logic                           can_issue,
    output logic                                iss_valid,
    output load_issue_pkg::load_dispatch_t      iss,
    output logic                                disp_credit
);

    localparam int idx_w = $clog2(rs_depth);

    load_issue_pkg::load_dispatch_t entry_q [rs_depth];
    logic [rs_depth-1:0]            free_q;     // one bit per entry, set when empty
    logic [rs_depth-1:0]            ready_vec;
    logic [idx_w-1:0]               wr_idx;
    logic [idx_w-1:0]               sel_idx;
    logic                           has_free;

    ////////////////////////////////////////
    // allocation and select
    ////////////////////////////////////////

    always_comb begin : find_free
        wr_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                wr_idx = idx_w'(i);  // lowest free wins
            end
        end
    end

    always_comb begin : find_ready
        for (int i = 0; i < rs_depth; i++) begin
            ready_vec[i] = !free_q[i] && entry_q[i].base_ready;
        end
    end

    always_comb begin : pick
        sel_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                sel_idx = idx_w'(i);
            end
        end
    end

    assign has_free  = |free_q;
    assign iss_valid = can_issue && (|ready_vec);
    assign iss       = entry_q[sel_idx];

    ////////////////////////////////////////
    // occupancy and credit return
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            free_q      <= '1;
            disp_credit <= 1'b0;
        end else if (flush) begin
            free_q      <= '1;
            disp_credit <= 1'b0;  // dispatcher refills on its own
        end else begin
            if (fwd_valid) begin
                free_q[wr_idx] <= 1'b0;
            end
            if (iss_valid) begin
                free_q[sel_idx] <= 1'b1;  // never the entry being written
            end
            disp_credit <= iss_valid;
        end
    end

    // entry payload, write of a new load or CDB wakeup of a waiting one
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (fwd_valid && free_q[i] && (wr_idx == idx_w'(i))) begin
                entry_q[i] <= fwd;
            end else if (cdb.valid && !free_q[i] && !entry_q[i].base_ready
                         && (entry_q[i].base[load_issue_pkg::preg_w-1:0] == cdb.tag)) begin
                entry_q[i].base_ready <= 1'b1;
                entry_q[i].base       <= cdb.value;
            end
        end
    end

    // dispatcher credit accounting must leave room for every forwarded load
    a_write_has_room: assert property (@(posedge clock) disable iff (!arst_n)
        fwd_valid |-> has_free);

    // the issuing entry and the entry taking the new load are distinct
    a_issue_not_written: assert property (@(posedge clock) disable iff (!arst_n)
        (iss_valid && fwd_valid) |-> (sel_idx != wr_idx));

endmodule

`default_nettype wire

// File: source/load_agen.sv
/*
 * load address generation
 * registers base plus offset with the load identity and tracks
 * credits held from the load buffer
 */

`timescale 1ns/1ps
`default_nettype none

module load_agen #(
    parameter int lb_credits = 4
) (
    input  wire logic                           clock,
    input  wire logic                           arst_n,
    input  wire logic                           flush,
    input  wire logic                           iss_valid,
    input  wire load_issue_pkg::load_dispatch_t iss,
    input  wire logic                           lb_credit,
    output logic                                can_issue,
    output logic                                req_valid,
    output load_issue_pkg::load_req_t           req
);

    localparam int cnt_w = $clog2(lb_credits + 1);

    logic [cnt_w-1:0] credits_q;
    logic             take;    // issue accepted this cycle
    logic             refund;  // request in flight killed by flush

    assign take   = iss_valid && !flush;
    assign refund = flush && req_valid;

    ////////////////////////////////////////
    // load buffer credits
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            credits_q <= cnt_w'(lb_credits);
        end else begin
            credits_q <= credits_q - cnt_w'(take) + cnt_w'(lb_credit) + cnt_w'(refund);
        end
    end

    assign can_issue = (credits_q != '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= take;
        end
    end

    // request payload
    always_ff @(posedge clock) begin
        if (take) begin
            req.addr        <= iss.base + iss.offset;
            req.dest_preg   <= iss.dest_preg;
            req.rob_idx     <= iss.rob_idx;
            req.lb_idx      <= iss.lb_idx;
            req.mem_size    <= iss.mem_size;
            req.load_signed <= iss.load_signed;
        end
    end

    // the load buffer may only return credits it was given
    a_credit_bound: assert property (@(posedge clock) disable iff (!arst_n)
        credits_q <= cnt_w'(lb_credits));

endmodule

`default_nettype wire

// File: source/load_issue_top.sv
/*
 * load issue slice top
 * dispatch register, reservation station and address generation
 */

`timescale 1ns/1ps
`default_nettype none

module load_issue_top #(
    parameter int rs_depth   = 8,
    parameter int lb_credits = 4
) (
    input  wire logic                           clock,
    input  wire logic                           arst_n,
    input  wire logic                           flush,
    input  wire logic                           disp_valid,
    input  wire load_issue_pkg::load_dispatch_t disp,
    input  wire load_issue_pkg::cdb_t           cdb,
    input  wire logic                           lb_credit,
    output logic                                disp_credit,
    output logic                                req_valid,
    output load_issue_pkg::load_req_t           req
);

    logic                           fwd_valid;
    load_issue_pkg::load_dispatch_t fwd;
    logic                           can_issue;
    logic                           iss_valid;
    load_issue_pkg::load_dispatch_t iss;

    dispatch_stage u_dispatch (
        .clock      (clock),
        .arst_n     (arst_n),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp       (disp),
        .cdb        (cdb),
        .fwd_valid  (fwd_valid),
        .fwd        (fwd)
    );

    load_rs #(.rs_depth(rs_depth)) u_rs (
        .clock       (clock),
        .arst_n      (arst_n),
        .flush       (flush),
        .fwd_valid   (fwd_valid),
        .fwd         (fwd),
        .cdb         (cdb),
        .can_issue   (can_issue),
        .iss_valid   (iss_valid),
        .iss         (iss),
        .disp_credit (disp_credit)
    );

    load_agen #(.lb_credits(lb_credits)) u_agen (
        .clock     (clock),
        .arst_n    (arst_n),
        .flush     (flush),
        .iss_valid (iss_valid),
        .iss       (iss),
        .lb_credit (lb_credit),
        .can_issue (can_issue),
        .req_valid (req_valid),
        .req       (req)
    );

endmodule

`default_nettype wire

// File: test/load_issue_model.svh
/*
 * load issue reference model
 * expected load buffer request of a dispatched load and a
 * scoreboard indexed by rob_idx
 */

`ifndef LOAD_ISSUE_MODEL_SVH
`define LOAD_ISSUE_MODEL_SVH

localparam int rob_slots = 2 ** load_issue_pkg::rob_w;

load_issue_pkg::load_req_t sb_req [rob_slots];
bit          sb_valid [rob_slots];
bit          sb_wait  [rob_slots];  // base not ready at dispatch
int unsigned sb_tag   [rob_slots];
int unsigned sb_gen   [rob_slots];  // broadcasts of sb_tag seen before dispatch
int unsigned sb_cycle [rob_slots];
int          sb_count;

// address is the base operand plus the offset, wrapping at xlen
function automatic load_issue_pkg::load_req_t expected_req(
    input load_issue_pkg::load_dispatch_t d,
    input logic [31:0]                    base_value
);
    load_issue_pkg::load_req_t r;
    r.addr        = base_value + d.offset;
    r.dest_preg   = d.dest_preg;
    r.rob_idx     = d.rob_idx;
    r.lb_idx      = d.lb_idx;
    r.mem_size    = d.mem_size;
    r.load_signed = d.load_signed;
    return r;
endfunction

function automatic void sb_clear();
    for (int i = 0; i < rob_slots; i++) begin
        sb_valid[i] = 1'b0;
    end
    sb_count = 0;
endfunction

// next rob_idx after last that has no load in flight
function automatic int free_rob(input int last);
    int idx;
    idx = last;
    for (int n = 0; n < rob_slots; n++) begin
        idx = (idx + 1) % rob_slots;
        if (!sb_valid[idx]) begin
            return idx;
        end
    end
    return 0;
endfunction

`endif

// File: test/tb_load_issue.sv
/*
 * testbench for the load issue slice
 * ready and waiting loads with CDB wakeup, load buffer back-pressure
 * and a mispredict flush, checked against a rob_idx scoreboard
 */

`timescale 1ns/1ps
`default_nettype none

module tb_load_issue;

    localparam int rs_depth   = 8;
    localparam int lb_credits = 4;
    localparam int n_loads    = 160;  // upper bound on dispatched loads
    localparam int tag_pool   = 16;   // tags used by waiting loads

    logic clock, arst_n, flush, disp_valid, lb_credit, disp_credit, req_valid;
    load_issue_pkg::load_dispatch_t disp;
    load_issue_pkg::cdb_t           cdb;
    load_issue_pkg::load_req_t      req;

    `include "load_issue_model.svh"

    logic [31:0] regval    [tag_pool];  // register file behind the tags
    bit          pending   [tag_pool];
    int unsigned bcast_cnt [tag_pool];
    int unsigned lb_due [$];            // cycle when the load buffer frees an entry
    int          lb_out;                // requests held by the load buffer
    bit          lb_hold;
    int          credits;               // dispatcher credit counter
    int unsigned cycle;
    int          loads_sent, reqs_seen, next_rob;

    load_issue_top #(.rs_depth(rs_depth), .lb_credits(lb_credits)) u_dut (.*);

    always #2 clock = ~clock;

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v)
        else fail_now($sformatf("FAIL t=%0t %s expected %0h actual %0h",
                                $time, name, exp_v, act_v));
    endtask

    ////////////////////////////////////////
    // one cycle of dispatcher, CDB and load buffer
    ////////////////////////////////////////

    task automatic drive_cycle(input int mode, input bit want_flush);
        load_issue_pkg::load_dispatch_t d;
        logic [31:0]                    base_value;
        int                             t;
        @(posedge clock);
        #0.5;
        cycle++;
        lb_credit = 1'b0;
        if (!lb_hold && lb_due.size() != 0 && lb_due[0] <= cycle) begin
            void'(lb_due.pop_front());
            lb_out--;
            lb_credit = 1'b1;
        end
        cdb = '0;
        t = $urandom_range(tag_pool - 1);
        if (pending[t] && $urandom_range(1) == 1) begin  // producer completes
            cdb.valid  = 1'b1;
            cdb.tag    = t[load_issue_pkg::preg_w-1:0];
            cdb.value  = regval[t];
            pending[t] = 1'b0;
            bcast_cnt[t]++;
        end
        flush      = want_flush;
        disp_valid = 1'b0;
        if (!want_flush && mode != 0 && credits > 0 && loads_sent < n_loads) begin
            next_rob      = free_rob(next_rob);
            d.offset      = $urandom();
            d.dest_preg   = $urandom_range(63);
            d.rob_idx     = next_rob[load_issue_pkg::rob_w-1:0];
            d.lb_idx      = $urandom_range(7);
            d.mem_size    = load_issue_pkg::mem_size_e'($urandom_range(2));
            d.load_signed = $urandom_range(1);
            base_value    = $urandom();
            d.base_ready  = 1'b1;
            d.base        = base_value;
            sb_wait[next_rob] = 1'b0;
            t = $urandom_range(tag_pool - 1);
            if (mode == 2 && $urandom_range(1) == 1) begin
                if (!pending[t] && !(cdb.valid && cdb.tag == t)) begin
                    regval[t]  = $urandom();
                    pending[t] = 1'b1;
                end
                base_value   = regval[t];
                d.base_ready = !pending[t];  // broadcast of this cycle folded in
                d.base       = d.base_ready ? base_value : (($urandom() & ~32'h3f) | t);
                sb_wait[next_rob] = !d.base_ready;
                sb_tag[next_rob]  = t;
                sb_gen[next_rob]  = bcast_cnt[t];
            end
            sb_req[next_rob]   = expected_req(d, base_value);
            sb_valid[next_rob] = 1'b1;
            sb_cycle[next_rob] = cycle;
            sb_count++;
            disp       = d;
            disp_valid = 1'b1;
            credits--;
            loads_sent++;
        end
    endtask

    task automatic check_request();
        load_issue_pkg::load_req_t e;
        int                        r;
        r = req.rob_idx;
        assert (sb_valid[r])
        else fail_now($sformatf("request at %0t for rob_idx %0d with no load pending",
                                $time, r));
        e = sb_req[r];
        check_field("req.addr", e.addr, req.addr);
        check_field("req.dest_preg", e.dest_preg, req.dest_preg);
        check_field("req.lb_idx", e.lb_idx, req.lb_idx);
        check_field("req.mem_size", e.mem_size, req.mem_size);
        check_field("req.load_signed", e.load_signed, req.load_signed);
        if (sb_wait[r]) begin
            assert (bcast_cnt[sb_tag[r]] != sb_gen[r])
            else fail_now($sformatf("rob_idx %0d issued before its base tag was broadcast", r));
        end
        if (reqs_seen == 0) begin
            check_field("req_valid latency", 3, cycle - sb_cycle[r]);
        end
        sb_valid[r] = 1'b0;
        sb_count--;
        reqs_seen++;
        lb_out++;
        assert (lb_out <= lb_credits)
        else fail_now($sformatf("%0d requests outstanding at the load buffer", lb_out));
        lb_due.push_back(cycle + $urandom_range(1, 10));
    endtask

    // outputs are registered, so the falling edge sees settled values
    always @(negedge clock) begin : compare
        if (arst_n && flush) begin
            credits = rs_depth;  // dispatcher refills on a mispredict
            sb_clear();
        end else if (arst_n) begin
            if (disp_credit) begin
                assert (credits < rs_depth)
                else fail_now("disp_credit pulse while no dispatcher credit was outstanding");
                credits++;
            end
            if (req_valid) begin
                check_request();
            end
        end
    end

    initial begin : watchdog
        repeat (n_loads * 40 + 200) @(posedge clock);
        fail_now("timeout: the loads did not drain in time");
    end

    initial begin : stimulus
        clock      = 1'b0;
        arst_n     = 1'b0;
        flush      = 1'b0;
        disp_valid = 1'b0;
        disp       = '0;
        cdb        = '0;
        lb_credit  = 1'b0;
        lb_hold    = 1'b0;
        credits    = rs_depth;
        lb_out     = 0;
        cycle      = 0;
        loads_sent = 0;
        reqs_seen  = 0;
        next_rob   = 0;
        sb_clear();
        void'($urandom(77));
        for (int i = 0; i < tag_pool; i++) begin
            regval[i] = $urandom();
        end
        repeat (4) @(posedge clock);
        #0.5 arst_n = 1'b1;

        drive_cycle(1, 1'b0);  // lone ready load, minimum latency
        repeat (6) drive_cycle(0, 1'b0);
        repeat (40) drive_cycle(($urandom_range(3) != 0) ? 2 : 0, 1'b0);
        lb_hold = 1'b1;        // load buffer keeps its credits
        repeat (40) drive_cycle(2, 1'b0);
        lb_hold = 1'b0;
        repeat (30) drive_cycle(2, 1'b0);
        drive_cycle(0, 1'b1);  // mispredict with loads in flight
        repeat (50) drive_cycle(($urandom_range(3) != 0) ? 2 : 0, 1'b0);
        while (sb_count != 0) begin
            drive_cycle(0, 1'b0);
        end
        repeat (8) drive_cycle(0, 1'b0);

        if (credits == rs_depth) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_now($sformatf("FAIL t=%0t credits expected %0d actual %0d",
                               $time, rs_depth, credits));
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+test
source/load_issue_pkg.sv
source/dispatch_stage.sv
source/load_rs.sv
source/load_agen.sv
source/load_issue_top.sv
test/tb_load_issue.sv
